/* bench/tb_cases.svh */
/* case table for the packet checker testbench where byte k of a packet is seed + k
   reload and flip hold 8'hff when unused, index is only compared for matches */

// expected packet length of each entry
localparam int entry_len [num_expected] = '{4, 3, 9, 16, 22, 35, 64, 30};

typedef struct packed {
    logic [7:0]   reload;
    logic [7:0]   seed;
    logic [7:0]   len;
    logic [7:0]   flip;
    logic         gap;
    logic         all_chk;
    result_kind_t kind;
    entry_idx_t   index;
    blen_t        blen;
} case_t;

localparam int num_cases = 14;

// columns are reload, seed, len, flip, gap, all_chk, kind, index, blen
localparam case_t cases [num_cases] = '{
    '{8'hff, 8'd0, 8'd4,  8'hff, 1'b1, 1'b0, res_match,    3'd0, 7'd4},
    '{8'hff, 8'd1, 8'd3,  8'hff, 1'b1, 1'b0, res_match,    3'd1, 7'd3},
    '{8'hff, 8'd2, 8'd9,  8'hff, 1'b1, 1'b0, res_match,    3'd2, 7'd9},
    '{8'hff, 8'd3, 8'd16, 8'd10, 1'b1, 1'b0, res_no_match, 3'd0, 7'd16},
    '{8'hff, 8'd3, 8'd15, 8'hff, 1'b1, 1'b0, res_no_match, 3'd0, 7'd15},
    '{8'hff, 8'd3, 8'd16, 8'hff, 1'b1, 1'b0, res_match,    3'd3, 7'd16},
    // entry 1 is already claimed here
    '{8'hff, 8'd1, 8'd3,  8'hff, 1'b1, 1'b0, res_no_match, 3'd0, 7'd3},
    '{8'hff, 8'd4, 8'd22, 8'hff, 1'b1, 1'b0, res_match,    3'd4, 7'd22},
    '{8'hff, 8'd5, 8'd35, 8'hff, 1'b1, 1'b0, res_match,    3'd5, 7'd35},
    '{8'hff, 8'd6, 8'd64, 8'hff, 1'b1, 1'b0, res_match,    3'd6, 7'd64},
    // 17 beats of which only the first 64 bytes are kept
    '{8'hff, 8'd0, 8'd68, 8'hff, 1'b1, 1'b0, res_oversize, 3'd0, 7'd64},
    // the short packet lands while entry 7 is still being searched for
    '{8'hff, 8'd7, 8'd30, 8'hff, 1'b0, 1'b0, res_match,    3'd7, 7'd30},
    '{8'hff, 8'd0, 8'd2,  8'hff, 1'b1, 1'b1, res_overrun,  3'd0, 7'd2},
    '{8'd1,  8'd1, 8'd3,  8'hff, 1'b1, 1'b0, res_match,    3'd1, 7'd3}
};

/* bench/tb_axis_pkt_checker.sv */
/* drives packets with random tready stalls into the checker, seed is fixed
   results of one group are paired with case rows by their kind */
`timescale 1ns/1ps
`default_nettype none

module tb_axis_pkt_checker import pkt_chk_pkg::*; ();

    logic       axis_in = 1'b0;
    logic       reset;
    axis_beat_t beat;
    logic       load_we;
    entry_idx_t load_index;
    packet_t    load_data;
    blen_t      load_blen;
    result_t    result;
    count_t     match_count;
    count_t     miss_count;
    logic       all_received;

    int          errors;
    int          case_errors;
    int          cases_done;
    int          matches_exp;
    int          misses_exp;
    int          first_pending;
    bit          timed_out;
    entry_mask_t claimed_exp;
    result_t     got_q [$];

    `include "tb_cases.svh"

    axis_pkt_checker i_axis_pkt_checker (
        .axis_in      (axis_in),
        .reset        (reset),
        .beat         (beat),
        .load_we      (load_we),
        .load_index   (load_index),
        .load_data    (load_data),
        .load_blen    (load_blen),
        .result       (result),
        .match_count  (match_count),
        .miss_count   (miss_count),
        .all_received (all_received)
    );

    always #5 axis_in = ~axis_in;

    // values seen here are the ones held during the cycle before the edge
    always @(posedge axis_in) begin
        if (!reset && result.valid) begin
            got_q.push_back(result);
        end
    end

    task automatic load_entry(input int idx);
        packet_t p;
        for (int k = 0; k < mtu_bytes; k++) begin
            p[k*8 +: 8] = 8'(idx + k);
        end
        @(posedge axis_in);
        load_we    <= 1'b1;
        load_index <= entry_idx_t'(idx);
        load_data  <= p;
        load_blen  <= blen_t'(entry_len[idx]);
        @(posedge axis_in);
        load_we    <= 1'b0;
    endtask

    task automatic send_beat(input word_t data, input keep_t keep, input logic last);
        int stalls;
        stalls = (($urandom % 4) == 0) ? 1 + int'($urandom % 2) : 0;
        // beat is offered but tready holds it off
        for (int s = 0; s < stalls; s++) begin
            @(posedge axis_in);
            beat <= '{tvalid: 1'b1, tready: 1'b0, tdata: data, tkeep: keep, tlast: last};
        end
        @(posedge axis_in);
        beat <= '{tvalid: 1'b1, tready: 1'b1, tdata: data, tkeep: keep, tlast: last};
    endtask

    task automatic send_packet(input int seed, input int len, input int flip);
        int    nbeats;
        int    pos;
        word_t w;
        keep_t kp;
        nbeats = (len + data_bytes - 1) / data_bytes;
        for (int b = 0; b < nbeats; b++) begin
            for (int j = 0; j < data_bytes; j++) begin
                pos = b * data_bytes + j;
                kp[j] = (pos < len);
                // filler past the end must be ignored by the checker
                w[j*8 +: 8] = (pos < len) ? 8'(seed + pos) : 8'hee;
                if (pos == flip) begin
                    w[j*8 +: 8] = w[j*8 +: 8] ^ 8'h5a;
                end
            end
            send_beat(w, kp, b == nbeats - 1);
        end
    endtask

    task automatic wait_results(input int count, output bit ok);
        ok = 1'b0;
        for (int c = 0; c < 200 && !ok; c++) begin
            @(negedge axis_in);
            ok = (got_q.size() >= count);
        end
    endtask

    task automatic check_case(input int r);
        case_t   c;
        result_t got;
        int      found;
        c = cases[r];
        found = -1;
        case_errors = 0;
        foreach (got_q[i]) begin
            if (found < 0 && got_q[i].kind == c.kind) begin
                found = i;
            end
        end
        assert (found >= 0) else begin
            if (got_q.size() > 0) begin
                $display("[FAIL] time %0t result.kind got %0d expected %0d",
                         $time, got_q[0].kind, c.kind);
            end else begin
                $display("case %0d: no result of kind %0d arrived", r, c.kind);
            end
            case_errors++;
        end
        if (found >= 0) begin
            got = got_q[found];
            got_q.delete(found);
            if (c.kind == res_match) begin
                assert (got.index == c.index) else begin
                    $display("[FAIL] time %0t result.index got %0d expected %0d",
                             $time, got.index, c.index);
                    case_errors++;
                end
            end
            assert (got.blen == c.blen) else begin
                $display("[FAIL] time %0t result.blen got %0d expected %0d",
                         $time, got.blen, c.blen);
                case_errors++;
            end
        end
        if (c.kind == res_match) begin
            matches_exp++;
            claimed_exp[c.index] = 1'b1;
        end else begin
            misses_exp++;
        end
        errors += case_errors;
        cases_done++;
        $display("case %0d: seed %0d len %0d kind %0d %s", r, c.seed, c.len, c.kind,
                 (case_errors == 0) ? "ok" : "mismatch");
    endtask

    task automatic check_counters(input int r);
        assert (got_q.size() == 0) else begin
            $display("unexpected extra result after case %0d", r);
            errors++;
        end
        got_q.delete();
        assert (match_count == count_t'(matches_exp)) else begin
            $display("[FAIL] time %0t match_count got %0d expected %0d",
                     $time, match_count, matches_exp);
            errors++;
        end
        assert (miss_count == count_t'(misses_exp)) else begin
            $display("[FAIL] time %0t miss_count got %0d expected %0d",
                     $time, miss_count, misses_exp);
            errors++;
        end
        // high only while every entry has matched since its last load
        assert (all_received == &claimed_exp) else begin
            $display("[FAIL] time %0t all_received got %0d expected %0d",
                     $time, all_received, &claimed_exp);
            errors++;
        end
        if (cases[r].all_chk) begin
            assert (match_count == count_t'(num_expected)) else begin
                $display("[FAIL] time %0t match_count got %0d expected %0d",
                         $time, match_count, num_expected);
                errors++;
            end
        end
    endtask

    initial begin
        bit ok;
        void'($urandom(32'h27df_0b37));
        reset = 1'b1;
        beat = '0;
        load_we = 1'b0;
        load_index = '0;
        load_data = '0;
        load_blen = '0;
        errors = 0;
        cases_done = 0;
        matches_exp = 0;
        misses_exp = 0;
        first_pending = 0;
        timed_out = 1'b0;
        claimed_exp = '0;
        repeat (16) @(posedge axis_in);
        reset <= 1'b0;
        for (int i = 0; i < num_expected; i++) begin
            load_entry(i);
        end
        for (int r = 0; r < num_cases && !timed_out; r++) begin
            if (cases[r].reload != 8'hff) begin
                claimed_exp[entry_idx_t'(cases[r].reload)] = 1'b0;
                load_entry(int'(cases[r].reload));
            end
            send_packet(cases[r].seed, cases[r].len, cases[r].flip);
            if (cases[r].gap) begin
                @(posedge axis_in);
                beat <= '0;
                wait_results(r + 1 - first_pending, ok);
                if (!ok) begin
                    $display("timed out waiting for the result of case %0d", r);
                    timed_out = 1'b1;
                end else begin
                    // a few more cycles so that stray results show up
                    repeat (3) @(negedge axis_in);
                    for (int p = first_pending; p <= r; p++) begin
                        check_case(p);
                    end
                    check_counters(r);
                end
                first_pending = r + 1;
            end
        end
        $display("cases %0d of %0d, matches %0d, misses %0d, errors %0d",
                 cases_done, num_cases, matches_exp, misses_exp, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* capture/beat_capture.sv */
/* packet image is not cleared between packets, bytes above blen are stale
   beats past mtu_words are dropped and the packet is flagged oversize */
`timescale 1ns/1ps
`default_nettype none

module beat_capture import pkt_chk_pkg::*; (
    input  logic       axis_in,
    input  logic       reset,
    input  axis_beat_t beat,
    output captured_t  captured
);

    word_ptr_t word_ptr;
    blen_t     byte_cnt;
    logic      overflow;
    packet_t   image_q;
    logic      done_q;
    blen_t     blen_q;
    logic      oversize_q;
    logic      accept;

    // number of valid bytes in the last beat
    function automatic blen_t keep_bytes(input keep_t keep);
        blen_t n;
        n = '0;
        for (int i = 0; i < data_bytes; i++) begin
            n = n + blen_t'(keep[i]);
        end
        return n;
    endfunction

    assign accept = beat.tvalid & beat.tready;

    // pointer, byte count and overflow state
    always_ff @(posedge axis_in) begin
        if (reset) begin
            word_ptr <= '0;
            byte_cnt <= '0;
            overflow <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= accept & beat.tlast;
            if (accept) begin
                if (beat.tlast) begin
                    word_ptr <= '0;
                    byte_cnt <= '0;
                    overflow <= 1'b0;
                end else if (!overflow) begin
                    byte_cnt <= byte_cnt + blen_t'(data_bytes);
                    if (word_ptr == word_ptr_t'(mtu_words - 1)) begin
                        overflow <= 1'b1;
                    end else begin
                        word_ptr <= word_ptr + 1'b1;
                    end
                end
            end
        end
    end

    // payload image
    always_ff @(posedge axis_in) begin
        if (accept && !overflow) begin
            image_q[word_ptr*data_bytes*8 +: data_bytes*8] <= beat.tdata;
        end
        if (accept && beat.tlast) begin
            oversize_q <= overflow;
            // an oversize packet reports the bytes it kept
            blen_q     <= overflow ? blen_t'(mtu_bytes) : byte_cnt + keep_bytes(beat.tkeep);
        end
    end

    // image is read by the matcher in the same cycle done is high
    assign captured = '{
        done:     done_q,
        data:     image_q,
        blen:     blen_q,
        oversize: oversize_q
    };

endmodule

`default_nettype wire

/* common/pkt_chk_pkg.sv */
/* sizes, vector types and structs shared by the packet checker
   one stream of 4-byte beats, packets up to 64 bytes, 8 expected entries */
`default_nettype none

package pkt_chk_pkg;

    localparam int data_bytes   = 4;
    localparam int mtu_bytes    = 64;
    localparam int mtu_words    = mtu_bytes / data_bytes;
    localparam int num_expected = 8;

    typedef logic [data_bytes*8-1:0]        word_t;
    typedef logic [data_bytes-1:0]          keep_t;
    // byte 0 of the packet sits in bits 7:0
    typedef logic [mtu_bytes*8-1:0]         packet_t;
    // lengths run from 0 to mtu_bytes inclusive
    typedef logic [$clog2(mtu_bytes+1)-1:0] blen_t;
    typedef logic [$clog2(mtu_words)-1:0]   word_ptr_t;
    typedef logic [$clog2(num_expected)-1:0] entry_idx_t;
    typedef logic [num_expected-1:0]        entry_mask_t;
    typedef logic [15:0]                    count_t;

    typedef enum logic [1:0] {
        res_match    = 2'd0,
        res_no_match = 2'd1,
        res_oversize = 2'd2,
        res_overrun  = 2'd3
    } result_kind_t;

    // the monitored stream as seen on the wire
    typedef struct packed {
        logic  tvalid;
        logic  tready;
        word_t tdata;
        keep_t tkeep;
        logic  tlast;
    } axis_beat_t;

    typedef struct packed {
        logic    done;
        packet_t data;
        blen_t   blen;
        logic    oversize;
    } captured_t;

    typedef struct packed {
        logic         valid;
        result_kind_t kind;
        entry_idx_t   index;
        blen_t        blen;
    } result_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+bench
common/pkt_chk_pkg.sv
capture/beat_capture.sv
logic/expected_table.sv
logic/packet_matcher.sv
logic/check_report.sv
logic/axis_pkt_checker.sv
bench/tb_axis_pkt_checker.sv

/* logic/axis_pkt_checker.sv */
/* passive AXI-stream packet checker, never drives tready
   a packet ending during a running search is reported as overrun */
`timescale 1ns/1ps
`default_nettype none

module axis_pkt_checker import pkt_chk_pkg::*; (
    input  logic       axis_in,
    input  logic       reset,
    input  axis_beat_t beat,
    input  logic       load_we,
    input  entry_idx_t load_index,
    input  packet_t    load_data,
    input  blen_t      load_blen,
    output result_t    result,
    output count_t     match_count,
    output count_t     miss_count,
    output logic       all_received
);

    captured_t   captured;
    entry_idx_t  rd_index;
    packet_t     rd_data;
    blen_t       rd_blen;
    entry_mask_t claimed;
    result_t     match_result;

    beat_capture i_beat_capture (
        .axis_in  (axis_in),
        .reset    (reset),
        .beat     (beat),
        .captured (captured)
    );

    expected_table i_expected_table (
        .axis_in    (axis_in),
        .reset      (reset),
        .load_we    (load_we),
        .load_index (load_index),
        .load_data  (load_data),
        .load_blen  (load_blen),
        .rd_index   (rd_index),
        .rd_data    (rd_data),
        .rd_blen    (rd_blen)
    );

    packet_matcher i_packet_matcher (
        .axis_in  (axis_in),
        .reset    (reset),
        .captured (captured),
        .claimed  (claimed),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .rd_blen  (rd_blen),
        .result   (match_result)
    );

    check_report i_check_report (
        .axis_in      (axis_in),
        .reset        (reset),
        .match_in     (match_result),
        .load_we      (load_we),
        .load_index   (load_index),
        .claimed      (claimed),
        .result       (result),
        .match_count  (match_count),
        .miss_count   (miss_count),
        .all_received (all_received)
    );

endmodule

`default_nettype wire

/* logic/check_report.sv */
/* claimed bits are set by matches and cleared when the entry is reloaded
   counters wrap at 16 bits */
`timescale 1ns/1ps
`default_nettype none

module check_report import pkt_chk_pkg::*; (
    input  logic        axis_in,
    input  logic        reset,
    input  result_t     match_in,
    input  logic        load_we,
    input  entry_idx_t  load_index,
    output entry_mask_t claimed,
    output result_t     result,
    output count_t      match_count,
    output count_t      miss_count,
    output logic        all_received
);

    entry_mask_t claimed_q;
    entry_mask_t claimed_next;
    logic        valid_q;
    result_t     payload_q;
    logic        is_match;

    assign is_match = match_in.valid && (match_in.kind == res_match);

    // a reload wins over a match on the same entry
    always_comb begin
        claimed_next = claimed_q;
        if (is_match) begin
            claimed_next[match_in.index] = 1'b1;
        end
        if (load_we) begin
            claimed_next[load_index] = 1'b0;
        end
    end

    always_ff @(posedge axis_in) begin
        if (reset) begin
            claimed_q   <= '0;
            match_count <= '0;
            miss_count  <= '0;
            valid_q     <= 1'b0;
        end else begin
            claimed_q <= claimed_next;
            valid_q   <= match_in.valid;
            if (is_match) begin
                match_count <= match_count + 1'b1;
            end else if (match_in.valid) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_in) begin
        payload_q <= match_in;
    end

    assign claimed      = claimed_q;
    assign all_received = &claimed_q;
    assign result       = '{valid: valid_q, kind: payload_q.kind,
                            index: payload_q.index, blen: payload_q.blen};

endmodule

`default_nettype wire

/* logic/expected_table.sv */
/* register file of expected packets, one whole entry per load strobe
   reads are combinational, reset only clears the lengths */
`timescale 1ns/1ps
`default_nettype none

module expected_table import pkt_chk_pkg::*; (
    input  logic       axis_in,
    input  logic       reset,
    input  logic       load_we,
    input  entry_idx_t load_index,
    input  packet_t    load_data,
    input  blen_t      load_blen,
    input  entry_idx_t rd_index,
    output packet_t    rd_data,
    output blen_t      rd_blen
);

    packet_t pkt_mem  [num_expected];
    blen_t   blen_mem [num_expected];

    // packet bytes
    always_ff @(posedge axis_in) begin
        if (load_we) begin
            pkt_mem[load_index] <= load_data;
        end
    end

    // lengths start at zero so an unloaded entry only matches an empty packet
    always_ff @(posedge axis_in) begin
        if (reset) begin
            for (int i = 0; i < num_expected; i++) begin
                blen_mem[i] <= '0;
            end
        end else if (load_we) begin
            blen_mem[load_index] <= load_blen;
        end
    end

    assign rd_data = pkt_mem[rd_index];
    assign rd_blen = blen_mem[rd_index];

endmodule

`default_nettype wire

/* logic/packet_matcher.sv */
/* entry 0 is checked in the done cycle, then one entry per cycle
   up to three overrun results can wait for a free result slot */
`timescale 1ns/1ps
`default_nettype none

module packet_matcher import pkt_chk_pkg::*; (
    input  logic        axis_in,
    input  logic        reset,
    input  captured_t   captured,
    input  entry_mask_t claimed,
    output entry_idx_t  rd_index,
    input  packet_t     rd_data,
    input  blen_t       rd_blen,
    output result_t     result
);

    typedef enum logic {st_idle, st_search} state_t;

    state_t       state;
    entry_idx_t   idx_q;
    packet_t      pkt_q;
    blen_t        blen_q;
    logic [1:0]   pend_q;
    blen_t        ovr_blen_q;
    packet_t      cur_data;
    blen_t        cur_blen;
    entry_idx_t   cur_idx;
    packet_t      byte_mask;
    logic         hit;
    logic         last;
    logic         res_valid;
    result_kind_t res_kind;
    entry_idx_t   res_index;
    blen_t        res_blen;

    // in idle the fresh capture is compared directly against entry 0
    assign cur_data = (state == st_search) ? pkt_q : captured.data;
    assign cur_blen = (state == st_search) ? blen_q : captured.blen;
    assign cur_idx  = (state == st_search) ? idx_q : '0;
    assign rd_index = cur_idx;
    assign last     = (cur_idx == entry_idx_t'(num_expected - 1));

    always_comb begin
        for (int b = 0; b < mtu_bytes; b++) begin
            byte_mask[b*8 +: 8] = (b < cur_blen) ? 8'hff : 8'h00;
        end
    end

    assign hit = !claimed[cur_idx] && (cur_blen == rd_blen) &&
                 (((cur_data ^ rd_data) & byte_mask) == '0);

    always_ff @(posedge axis_in) begin
        if (reset) begin
            state     <= st_idle;
            idx_q     <= '0;
            pend_q    <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (captured.done && (captured.oversize || hit)) begin
                        res_valid <= 1'b1;
                        res_kind  <= captured.oversize ? res_oversize : res_match;
                        res_index <= '0;
                        res_blen  <= captured.blen;
                    end else if (captured.done) begin
                        pkt_q  <= captured.data;
                        blen_q <= captured.blen;
                        idx_q  <= entry_idx_t'(1);
                        state  <= st_search;
                    end else if (pend_q != '0) begin
                        res_valid <= 1'b1;
                        res_kind  <= res_overrun;
                        res_index <= '0;
                        res_blen  <= ovr_blen_q;
                        pend_q    <= pend_q - 1'b1;
                    end
                end
                st_search: begin
                    if (hit || last) begin
                        res_valid <= 1'b1;
                        res_kind  <= hit ? res_match : res_no_match;
                        res_index <= idx_q;
                        res_blen  <= blen_q;
                        state     <= st_idle;
                        // result slot taken, so the dropped packet waits
                        if (captured.done) begin
                            ovr_blen_q <= captured.blen;
                            if (pend_q != 2'b11) begin
                                pend_q <= pend_q + 1'b1;
                            end
                        end
                    end else begin
                        idx_q <= idx_q + 1'b1;
                        if (captured.done || pend_q != '0) begin
                            res_valid <= 1'b1;
                            res_kind  <= res_overrun;
                            res_index <= '0;
                            res_blen  <= captured.done ? captured.blen : ovr_blen_q;
                        end
                        if (!captured.done && pend_q != '0) begin
                            pend_q <= pend_q - 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign result = '{valid: res_valid, kind: res_kind, index: res_index, blen: res_blen};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the packet checker testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_axis_pkt_checker -o sim_tb > build.log 2>&1 &&
    ./obj_dir/sim_tb > sim.log 2>&1

grep -qx "TEST PASS" sim.log 2>/dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }
